// File: verilog/cpu_pkg.sv
package cpu_pkg;

	typedef logic [31:0] word_t;
	typedef logic [63:0] instr_t;
	typedef logic [3:0] reg_addr_t;
	typedef logic [1:0] lanes_t;

	// Type field, bits 31:28. Unlisted codes retire without a write.
	typedef enum logic [3:0] {
		T_CMP   = 4'h3,
		T_MOV   = 4'h4,
		T_INTU  = 4'h5,
		T_ALU   = 4'h7,
		T_LOAD  = 4'h8,
		T_STORE = 4'h9,
		T_LDI   = 4'ha
	} instr_type_e;

	// Op field, bits 27:24.
	typedef enum logic [3:0] {
		ADD = 4'h0,
		SUB = 4'h1,
		AND = 4'h2,
		OR  = 4'h3,
		XOR = 4'h4,
		SHL = 4'h5,
		SHR = 4'h6
	} alu_op_e;

	typedef struct packed {
		instr_t instr;
		word_t pc;
	} fetch_pkt_t;

	typedef struct packed {
		instr_t instr;
		word_t pc;
		word_t op1;
		word_t op2;
		lanes_t lanes;
	} decoded_t;

	typedef struct packed {
		reg_addr_t dest;
		word_t data;
		lanes_t lanes;
	} commit_t;

	function automatic instr_type_e instr_type(instr_t ir);
		return instr_type_e'(ir[31:28]);
	endfunction

	function automatic alu_op_e instr_op(instr_t ir);
		return alu_op_e'(ir[27:24]);
	endfunction

	function automatic reg_addr_t reg_a(instr_t ir);
		return ir[23:20];
	endfunction

	function automatic reg_addr_t reg_b(instr_t ir);
		return ir[19:16];
	endfunction

	function automatic reg_addr_t reg_c(instr_t ir);
		return ir[15:12];
	endfunction

	function automatic word_t instr_imm(instr_t ir);
		return ir[63:32];
	endfunction

endpackage

// File: verilog/register_file.sv
`timescale 1ns/1ps

module register_file(
	input logic clk_i,
	input logic rst_i,
	input logic supervisor_i,
	input cpu_pkg::reg_addr_t rd_addr1_i,
	input cpu_pkg::reg_addr_t rd_addr2_i,
	output cpu_pkg::word_t rd_data1_o,
	output cpu_pkg::word_t rd_data2_o,
	input cpu_pkg::commit_t wr_i,
	input logic wr_valid_i
);

	localparam cpu_pkg::reg_addr_t BANKED_REG = 4'hf;

	cpu_pkg::word_t regs [16];
	cpu_pkg::word_t sup_r15;
	cpu_pkg::word_t wr_old;
	cpu_pkg::word_t wr_new;
	logic wr_sup;

	// Register 15 reads from the supervisor copy in supervisor mode.
	assign rd_data1_o = (supervisor_i && rd_addr1_i == BANKED_REG) ?
		sup_r15 : regs[rd_addr1_i];
	assign rd_data2_o = (supervisor_i && rd_addr2_i == BANKED_REG) ?
		sup_r15 : regs[rd_addr2_i];

	assign wr_sup = supervisor_i && (wr_i.dest == BANKED_REG);
	assign wr_old = wr_sup ? sup_r15 : regs[wr_i.dest];

	// Merge the enabled half-words into the old value.
	always_comb
	begin
		wr_new = wr_old;
		if (wr_i.lanes[0])
			wr_new[15:0] = wr_i.data[15:0];
		if (wr_i.lanes[1])
			wr_new[31:16] = wr_i.data[31:16];
	end

	always_ff @(posedge clk_i or posedge rst_i)
	begin
		if (rst_i)
		begin
			for (int i = 0; i < 16; i++)
				regs[i] <= '0;
			sup_r15 <= '0;
		end
		else if (wr_valid_i && wr_i.lanes != '0)
		begin
			if (wr_sup)
				sup_r15 <= wr_new;
			else
				regs[wr_i.dest] <= wr_new;
		end
	end

endmodule

// File: verilog/instr_queue.sv
`timescale 1ns/1ps

module instr_queue #(
	parameter int QUEUE_DEPTH = 4
) (
	input logic clk_i,
	input logic rst_i,
	input logic in_valid_i,
	input cpu_pkg::fetch_pkt_t in_pkt_i,
	input logic pop_i,
	output cpu_pkg::fetch_pkt_t head_pkt_o,
	output logic head_valid_o,
	output logic credit_o
);

	localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
	localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

	cpu_pkg::fetch_pkt_t mem [QUEUE_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic do_pop;

	// Wrap at the depth, which need not be a power of two.
	function automatic logic [PTR_W-1:0] ptr_inc(logic [PTR_W-1:0] p);
		if (p == PTR_W'(QUEUE_DEPTH - 1))
			return '0;
		return p + 1'b1;
	endfunction

	assign head_valid_o = (count != '0);
	assign head_pkt_o = mem[rd_ptr];
	assign do_pop = pop_i && head_valid_o;

	// The source holds a credit per free slot, so a push always fits.
	always_ff @(posedge clk_i)
	begin
		if (in_valid_i)
			mem[wr_ptr] <= in_pkt_i;
	end

	always_ff @(posedge clk_i or posedge rst_i)
	begin
		if (rst_i)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			credit_o <= 1'b0;
		end
		else
		begin
			// One credit back per entry handed to decode.
			credit_o <= do_pop;
			if (in_valid_i)
				wr_ptr <= ptr_inc(wr_ptr);
			if (do_pop)
				rd_ptr <= ptr_inc(rd_ptr);
			count <= count + CNT_W'(in_valid_i) - CNT_W'(do_pop);
		end
	end

endmodule

// File: verilog/instr_decode.sv
`timescale 1ns/1ps

module instr_decode(
	input logic clk_i,
	input logic rst_i,
	input cpu_pkg::fetch_pkt_t head_pkt_i,
	input logic head_valid_i,
	input logic stall_i,
	input logic supervisor_i,
	input cpu_pkg::commit_t wr_i,
	input logic wr_valid_i,
	output cpu_pkg::reg_addr_t rd_addr1_o,
	output cpu_pkg::reg_addr_t rd_addr2_o,
	output logic pop_o,
	output cpu_pkg::decoded_t dec_o,
	output logic dec_valid_o
);

	cpu_pkg::instr_type_e ir_type;
	logic [3:0] ir_op;
	cpu_pkg::reg_addr_t ir_ra;
	cpu_pkg::reg_addr_t ir_rb;
	cpu_pkg::reg_addr_t ir_rc;
	cpu_pkg::word_t rf_data1;
	cpu_pkg::word_t rf_data2;
	cpu_pkg::lanes_t lanes_next;

	assign ir_type = cpu_pkg::instr_type(head_pkt_i.instr);
	assign ir_op = cpu_pkg::instr_op(head_pkt_i.instr);
	assign ir_ra = cpu_pkg::reg_a(head_pkt_i.instr);
	assign ir_rb = cpu_pkg::reg_b(head_pkt_i.instr);
	assign ir_rc = cpu_pkg::reg_c(head_pkt_i.instr);

	// Head is taken on any edge without a stall.
	assign pop_o = head_valid_i && !stall_i;

	always_comb
	begin
		case (ir_type)
			cpu_pkg::T_INTU:
			begin
				rd_addr1_o = ir_rb;
				rd_addr2_o = ir_rb;
			end
			cpu_pkg::T_CMP, cpu_pkg::T_LOAD, cpu_pkg::T_STORE:
			begin
				rd_addr1_o = ir_ra;
				rd_addr2_o = ir_rb;
			end
			default:
			begin
				rd_addr1_o = ir_rb;
				rd_addr2_o = ir_rc;
			end
		endcase
	end

	// MOV picks its half-words from the low op bits.
	always_comb
	begin
		case (ir_type)
			cpu_pkg::T_ALU, cpu_pkg::T_INTU, cpu_pkg::T_LDI:
				lanes_next = 2'b11;
			cpu_pkg::T_MOV:
				lanes_next = ir_op[1:0];
			default:
				lanes_next = 2'b00;
		endcase
	end

	always_ff @(posedge clk_i or posedge rst_i)
	begin
		if (rst_i)
			dec_valid_o <= 1'b0;
		else
			dec_valid_o <= pop_o;
	end

	always_ff @(posedge clk_i)
	begin
		if (pop_o)
			dec_o <= '{instr: head_pkt_i.instr, pc: head_pkt_i.pc,
				op1: rf_data1, op2: rf_data2, lanes: lanes_next};
	end

	register_file rf_i(
		.clk_i(clk_i),
		.rst_i(rst_i),
		.supervisor_i(supervisor_i),
		.rd_addr1_i(rd_addr1_o),
		.rd_addr2_i(rd_addr2_o),
		.rd_data1_o(rf_data1),
		.rd_data2_o(rf_data2),
		.wr_i(wr_i),
		.wr_valid_i(wr_valid_i)
	);

endmodule

// File: verilog/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit(
	input cpu_pkg::fetch_pkt_t head_pkt_i,
	input logic head_valid_i,
	input cpu_pkg::reg_addr_t rd_addr1_i,
	input cpu_pkg::reg_addr_t rd_addr2_i,
	input cpu_pkg::decoded_t dec_i,
	input logic dec_valid_i,
	input cpu_pkg::commit_t commit_i,
	input logic commit_valid_i,
	output logic stall_o
);

	cpu_pkg::instr_type_e head_type;
	cpu_pkg::reg_addr_t dec_dest;
	logic use1;
	logic use2;
	logic dec_wr;
	logic com_wr;
	logic hit_dec;
	logic hit_com;

	assign head_type = cpu_pkg::instr_type(head_pkt_i.instr);

	// Operands the head really consumes.
	always_comb
	begin
		use1 = head_valid_i;
		use2 = head_valid_i;
		case (head_type)
			cpu_pkg::T_LDI:
			begin
				use1 = 1'b0;
				use2 = 1'b0;
			end
			cpu_pkg::T_INTU, cpu_pkg::T_MOV:
				use2 = 1'b0;
			default:
				use2 = head_valid_i;
		endcase
	end

	assign dec_dest = cpu_pkg::reg_a(dec_i.instr);
	assign dec_wr = dec_valid_i && (dec_i.lanes != '0);
	assign com_wr = commit_valid_i && (commit_i.lanes != '0);

	assign hit_dec = dec_wr && ((use1 && rd_addr1_i == dec_dest) ||
		(use2 && rd_addr2_i == dec_dest));
	assign hit_com = com_wr && ((use1 && rd_addr1_i == commit_i.dest) ||
		(use2 && rd_addr2_i == commit_i.dest));

	// Hold decode until the write has reached the register file.
	assign stall_o = hit_dec || hit_com;

endmodule

// File: verilog/int_execute.sv
`timescale 1ns/1ps

module int_execute(
	input logic clk_i,
	input logic rst_i,
	input cpu_pkg::decoded_t dec_i,
	input logic dec_valid_i,
	output cpu_pkg::commit_t commit_o,
	output logic commit_valid_o
);

	cpu_pkg::instr_type_e ex_type;
	cpu_pkg::alu_op_e ex_op;
	cpu_pkg::word_t imm;
	cpu_pkg::word_t alu_b;
	cpu_pkg::word_t alu_out;
	cpu_pkg::word_t result;
	cpu_pkg::word_t commit_data;

	assign ex_type = cpu_pkg::instr_type(dec_i.instr);
	assign ex_op = cpu_pkg::instr_op(dec_i.instr);
	assign imm = cpu_pkg::instr_imm(dec_i.instr);

	// Second operand is the immediate for INTU.
	assign alu_b = (ex_type == cpu_pkg::T_INTU) ? imm : dec_i.op2;

	always_comb
	begin
		case (ex_op)
			cpu_pkg::ADD:
				alu_out = dec_i.op1 + alu_b;
			cpu_pkg::SUB:
				alu_out = dec_i.op1 - alu_b;
			cpu_pkg::AND:
				alu_out = dec_i.op1 & alu_b;
			cpu_pkg::OR:
				alu_out = dec_i.op1 | alu_b;
			cpu_pkg::XOR:
				alu_out = dec_i.op1 ^ alu_b;
			cpu_pkg::SHL:
				alu_out = dec_i.op1 << alu_b[4:0];
			cpu_pkg::SHR:
				alu_out = dec_i.op1 >> alu_b[4:0];
			default:
				alu_out = '0;
		endcase
	end

	always_comb
	begin
		case (ex_type)
			cpu_pkg::T_ALU, cpu_pkg::T_INTU:
				result = alu_out;
			cpu_pkg::T_LDI:
				result = imm;
			cpu_pkg::T_MOV:
				result = dec_i.op1;
			default:
				result = '0;
		endcase
	end

	// No-write instructions still retire, carrying zero data.
	assign commit_data = (dec_i.lanes != '0) ? result : '0;

	always_ff @(posedge clk_i or posedge rst_i)
	begin
		if (rst_i)
			commit_valid_o <= 1'b0;
		else
			commit_valid_o <= dec_valid_i;
	end

	always_ff @(posedge clk_i)
	begin
		if (dec_valid_i)
		begin
			commit_o.dest <= cpu_pkg::reg_a(dec_i.instr);
			commit_o.data <= commit_data;
			commit_o.lanes <= dec_i.lanes;
		end
	end

endmodule

// File: verilog/cpu_core.sv
`timescale 1ns/1ps

module cpu_core #(
	parameter int QUEUE_DEPTH = 4
) (
	input logic clk_i,
	input logic rst_i,
	input logic supervisor_i,
	input logic in_valid_i,
	input cpu_pkg::fetch_pkt_t in_pkt_i,
	output logic credit_o,
	output cpu_pkg::commit_t commit_o,
	output logic commit_valid_o
);

	cpu_pkg::fetch_pkt_t head_pkt;
	logic head_valid;
	logic pop;
	logic stall;
	cpu_pkg::reg_addr_t rd_addr1;
	cpu_pkg::reg_addr_t rd_addr2;
	cpu_pkg::decoded_t dec;
	logic dec_valid;

	instr_queue #(
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) queue_i (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.in_valid_i(in_valid_i),
		.in_pkt_i(in_pkt_i),
		.pop_i(pop),
		.head_pkt_o(head_pkt),
		.head_valid_o(head_valid),
		.credit_o(credit_o)
	);

	hazard_unit hazard_i(
		.head_pkt_i(head_pkt),
		.head_valid_i(head_valid),
		.rd_addr1_i(rd_addr1),
		.rd_addr2_i(rd_addr2),
		.dec_i(dec),
		.dec_valid_i(dec_valid),
		.commit_i(commit_o),
		.commit_valid_i(commit_valid_o),
		.stall_o(stall)
	);

	// Registered commit doubles as the register file write port.
	instr_decode decode_i(
		.clk_i(clk_i),
		.rst_i(rst_i),
		.head_pkt_i(head_pkt),
		.head_valid_i(head_valid),
		.stall_i(stall),
		.supervisor_i(supervisor_i),
		.wr_i(commit_o),
		.wr_valid_i(commit_valid_o),
		.rd_addr1_o(rd_addr1),
		.rd_addr2_o(rd_addr2),
		.pop_o(pop),
		.dec_o(dec),
		.dec_valid_o(dec_valid)
	);

	int_execute execute_i(
		.clk_i(clk_i),
		.rst_i(rst_i),
		.dec_i(dec),
		.dec_valid_i(dec_valid),
		.commit_o(commit_o),
		.commit_valid_o(commit_valid_o)
	);

endmodule

// File: dv/cpu_core_tb.sv
`timescale 1ns/1ps

module cpu_core_tb;

	localparam int QUEUE_DEPTH = 4;
	localparam int CLK_PERIOD = 100;

	typedef struct packed {
		logic sup;
		cpu_pkg::instr_t instr;
	} row_t;

	logic clk_i;
	logic rst_i;
	logic supervisor_i;
	logic in_valid_i;
	cpu_pkg::fetch_pkt_t in_pkt_i;
	logic credit_o;
	cpu_pkg::commit_t commit_o;
	logic commit_valid_o;

	row_t rows[$];
	cpu_pkg::commit_t exp_q[$];
	cpu_pkg::word_t model_regs [16];
	cpu_pkg::word_t model_sup15;
	logic table_ready;
	int seed;
	int sent;
	int committed;
	int credit_pulses;
	int idx;
	int settle;

	cpu_core #(
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) cpu_core_i (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.supervisor_i(supervisor_i),
		.in_valid_i(in_valid_i),
		.in_pkt_i(in_pkt_i),
		.credit_o(credit_o),
		.commit_o(commit_o),
		.commit_valid_o(commit_valid_o)
	);

	initial
	begin
		clk_i = 1'b0;
		forever
			#(CLK_PERIOD / 2) clk_i = ~clk_i;
	end

	task automatic end_with_failure();
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic show_mismatch(string name, cpu_pkg::word_t got, cpu_pkg::word_t exp);
		$display("MISMATCH %s: got %h, expected %h", name, got, exp);
		end_with_failure();
	endtask

	// Field layout: imm 63:32, type 31:28, op 27:24, A 23:20, B 19:16, C 15:12.
	task automatic add_row(logic sup, logic [3:0] typ, logic [3:0] op, logic [3:0] ra,
		logic [3:0] rb, logic [3:0] rc, cpu_pkg::word_t imm);
		row_t row;
		row.sup = sup;
		row.instr = {imm, typ, op, ra, rb, rc, 12'h000};
		rows.push_back(row);
	endtask

	function automatic cpu_pkg::word_t alu_ref(logic [3:0] op, cpu_pkg::word_t x,
		cpu_pkg::word_t y);
		case (op)
			cpu_pkg::ADD:
				return x + y;
			cpu_pkg::SUB:
				return x - y;
			cpu_pkg::AND:
				return x & y;
			cpu_pkg::OR:
				return x | y;
			cpu_pkg::XOR:
				return x ^ y;
			cpu_pkg::SHL:
				return x << y[4:0];
			cpu_pkg::SHR:
				return x >> y[4:0];
			default:
				return '0;
		endcase
	endfunction

	function automatic cpu_pkg::word_t model_read(logic sup, logic [3:0] r);
		if (sup && r == 4'hf)
			return model_sup15;
		return model_regs[r];
	endfunction

	// Reference model, stepped once per instruction in program order.
	task automatic model_step(row_t row);
		logic [3:0] typ;
		logic [3:0] op;
		logic [3:0] ra;
		cpu_pkg::word_t imm;
		cpu_pkg::word_t vb;
		cpu_pkg::word_t vc;
		cpu_pkg::word_t res;
		cpu_pkg::word_t merged;
		cpu_pkg::lanes_t lanes;
		cpu_pkg::commit_t exp;
		typ = row.instr[31:28];
		op = row.instr[27:24];
		ra = row.instr[23:20];
		imm = row.instr[63:32];
		vb = model_read(row.sup, row.instr[19:16]);
		vc = model_read(row.sup, row.instr[15:12]);
		res = '0;
		lanes = 2'b00;
		case (typ)
			cpu_pkg::T_ALU:
			begin
				res = alu_ref(op, vb, vc);
				lanes = 2'b11;
			end
			cpu_pkg::T_INTU:
			begin
				res = alu_ref(op, vb, imm);
				lanes = 2'b11;
			end
			cpu_pkg::T_LDI:
			begin
				res = imm;
				lanes = 2'b11;
			end
			cpu_pkg::T_MOV:
			begin
				res = vb;
				lanes = op[1:0];
			end
			default:
				lanes = 2'b00;
		endcase
		if (lanes == 2'b00)
			res = '0;
		exp.dest = ra;
		exp.data = res;
		exp.lanes = lanes;
		exp_q.push_back(exp);
		merged = model_read(row.sup, ra);
		if (lanes[0])
			merged[15:0] = res[15:0];
		if (lanes[1])
			merged[31:16] = res[31:16];
		if (row.sup && ra == 4'hf)
			model_sup15 = merged;
		else
			model_regs[ra] = merged;
	endtask

	task automatic load_table();
		add_row(1'b0, cpu_pkg::T_LDI, 4'h0, 4'd1, 4'd0, 4'd0, 32'h1234_5678);
		add_row(1'b0, cpu_pkg::T_LDI, 4'h0, 4'd2, 4'd0, 4'd0, 32'h0000_0004);
		add_row(1'b0, cpu_pkg::T_ALU, cpu_pkg::ADD, 4'd3, 4'd1, 4'd2, 32'h0);
		add_row(1'b0, cpu_pkg::T_ALU, cpu_pkg::SUB, 4'd4, 4'd3, 4'd2, 32'h0);
		add_row(1'b0, cpu_pkg::T_ALU, cpu_pkg::AND, 4'd5, 4'd1, 4'd3, 32'h0);
		add_row(1'b0, cpu_pkg::T_ALU, cpu_pkg::OR, 4'd6, 4'd1, 4'd2, 32'h0);
		add_row(1'b0, cpu_pkg::T_ALU, cpu_pkg::XOR, 4'd7, 4'd6, 4'd1, 32'h0);
		add_row(1'b0, cpu_pkg::T_ALU, cpu_pkg::SHL, 4'd8, 4'd1, 4'd2, 32'h0);
		add_row(1'b0, cpu_pkg::T_ALU, cpu_pkg::SHR, 4'd9, 4'd1, 4'd2, 32'h0);
		add_row(1'b0, cpu_pkg::T_INTU, cpu_pkg::ADD, 4'd10, 4'd9, 4'd0, 32'h1111_0000);
		add_row(1'b0, cpu_pkg::T_INTU, cpu_pkg::XOR, 4'd11, 4'd10, 4'd0, 32'hffff_ffff);
		add_row(1'b0, cpu_pkg::T_LDI, 4'h0, 4'd12, 4'd0, 4'd0, 32'haaaa_bbbb);
		add_row(1'b0, cpu_pkg::T_MOV, 4'h1, 4'd12, 4'd1, 4'd0, 32'h0);
		add_row(1'b0, cpu_pkg::T_MOV, 4'h2, 4'd11, 4'd2, 4'd0, 32'h0);
		add_row(1'b0, cpu_pkg::T_MOV, 4'h3, 4'd13, 4'd12, 4'd0, 32'h0);
		add_row(1'b0, cpu_pkg::T_MOV, 4'h3, 4'd10, 4'd11, 4'd0, 32'h0);
		// No-write types, followed by reads of the same registers.
		add_row(1'b0, cpu_pkg::T_CMP, 4'h0, 4'd1, 4'd2, 4'd0, 32'h0);
		add_row(1'b0, cpu_pkg::T_LOAD, 4'h0, 4'd3, 4'd1, 4'd0, 32'h0);
		add_row(1'b0, cpu_pkg::T_STORE, 4'h0, 4'd4, 4'd2, 4'd0, 32'h0);
		add_row(1'b0, 4'hf, 4'h0, 4'd5, 4'd1, 4'd2, 32'h0);
		add_row(1'b0, cpu_pkg::T_ALU, cpu_pkg::ADD, 4'd6, 4'd3, 4'd4, 32'h0);
		add_row(1'b0, cpu_pkg::T_ALU, cpu_pkg::OR, 4'd7, 4'd5, 4'd1, 32'h0);
		// Banked register 15.
		add_row(1'b0, cpu_pkg::T_LDI, 4'h0, 4'd15, 4'd0, 4'd0, 32'h0000_0015);
		add_row(1'b1, cpu_pkg::T_LDI, 4'h0, 4'd15, 4'd0, 4'd0, 32'h5555_0000);
		add_row(1'b1, cpu_pkg::T_MOV, 4'h3, 4'd14, 4'd15, 4'd0, 32'h0);
		add_row(1'b1, cpu_pkg::T_INTU, cpu_pkg::ADD, 4'd15, 4'd15, 4'd0, 32'h0000_0001);
		add_row(1'b0, cpu_pkg::T_MOV, 4'h3, 4'd14, 4'd15, 4'd0, 32'h0);
		add_row(1'b0, cpu_pkg::T_ALU, cpu_pkg::ADD, 4'd13, 4'd15, 4'd14, 32'h0);
		add_row(1'b1, cpu_pkg::T_MOV, 4'h3, 4'd0, 4'd15, 4'd0, 32'h0);
		add_row(1'b0, cpu_pkg::T_MOV, 4'h3, 4'd1, 4'd15, 4'd0, 32'h0);
	endtask

	task automatic check_commit();
		cpu_pkg::commit_t exp;
		assert (exp_q.size() != 0)
		else
		begin
			$display("A commit arrived with no instruction outstanding.");
			end_with_failure();
		end
		exp = exp_q.pop_front();
		assert (commit_o.dest == exp.dest)
		else
			show_mismatch("commit_o.dest", 32'(commit_o.dest), 32'(exp.dest));
		assert (commit_o.lanes == exp.lanes)
		else
			show_mismatch("commit_o.lanes", 32'(commit_o.lanes), 32'(exp.lanes));
		assert (commit_o.data == exp.data)
		else
			show_mismatch("commit_o.data", commit_o.data, exp.data);
		committed++;
	endtask

	always @(posedge clk_i)
	begin
		if (!rst_i && commit_valid_o)
			check_commit();
	end

	always @(posedge clk_i)
	begin
		if (!rst_i && credit_o)
			credit_pulses++;
	end

	initial
	begin
		wait (table_ready);
		#(CLK_PERIOD * (10 + 20 * rows.size()));
		$display("Watchdog expired with %0d of %0d commits seen.", committed, rows.size());
		end_with_failure();
	end

	initial
	begin
		rst_i = 1'b1;
		supervisor_i = 1'b0;
		in_valid_i = 1'b0;
		in_pkt_i = '0;
		seed = 32'h58f9_fc37;
		sent = 0;
		committed = 0;
		credit_pulses = 0;
		settle = 0;
		for (int i = 0; i < 16; i++)
			model_regs[i] = '0;
		model_sup15 = '0;
		load_table();
		table_ready = 1'b1;
		repeat (10) @(negedge clk_i);
		rst_i = 1'b0;
		idx = 0;
		while (idx < rows.size())
		begin
			@(negedge clk_i);
			in_valid_i = 1'b0;
			if (rows[idx].sup != supervisor_i)
			begin
				// Mode switch waits for an empty pipeline and the last write.
				if (committed == sent)
					settle++;
				else
					settle = 0;
				if (settle >= 2)
				begin
					supervisor_i = rows[idx].sup;
					settle = 0;
				end
			end
			else if (QUEUE_DEPTH - sent + credit_pulses > 0 && ($random(seed) & 3) != 0)
			begin
				in_pkt_i.instr = rows[idx].instr;
				in_pkt_i.pc = cpu_pkg::word_t'(idx * 8);
				in_valid_i = 1'b1;
				model_step(rows[idx]);
				sent++;
				idx++;
			end
		end
		@(negedge clk_i);
		in_valid_i = 1'b0;
		wait (committed == rows.size());
		repeat (4) @(negedge clk_i);
		assert (credit_pulses == sent)
		else
			show_mismatch("credit_o pulses", 32'(credit_pulses), 32'(sent));
		$display("Test completed successfully");
		$finish;
	end

endmodule

// File: filelist.f
verilog/cpu_pkg.sv
verilog/register_file.sv
verilog/instr_queue.sv
verilog/instr_decode.sv
verilog/hazard_unit.sv
verilog/int_execute.sv
verilog/cpu_core.sv
dv/cpu_core_tb.sv

// File: Makefile
# Verilator build and run for the CPU core testbench.

VERILATOR ?= verilator
TOP ?= cpu_core_tb
FILELIST ?= filelist.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
